// File: src.f
dcache_pkg.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_miss_ctrl.sv
dcache.sv
tb_dcache.sv

// File: run_sim.sh
#!/bin/sh
# builds the data cache testbench with Verilator, runs it into sim.log
# and looks for the failure line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_dcache -f src.f -o tb_dcache \
    && ./obj_dir/tb_dcache > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -qF '** FAIL **' sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0

// File: tb_dcache.sv
//##########################################################################
// testbench for the data cache
// memory model with random wait states, stimulus table applied in a loop,
// compare tasks and a watchdog
//##########################################################################
`timescale 1ns/1ns
`default_nettype none

module tb_dcache;

    localparam int                N_ENTRIES    = 15;
    localparam int                RESET_CYCLES = 8;
    localparam dcache_pkg::word_t FILL_PAT     = 32'hA5A5_0000;

    typedef enum logic {OP_RD, OP_WR} op_t;

    typedef struct packed {
        op_t               op;
        dcache_pkg::word_t addr;
        dcache_pkg::word_t wdata;
        dcache_pkg::word_t rdata;
        logic              hit_first;  // hit expected in the cycle the request is applied
        int                n_wb;       // memory writes expected during the entry
        dcache_pkg::word_t wb_blk;     // block address of the evicted dirty block
    } entry_t;

    logic                 CLK;
    logic                 nRST;
    dcache_pkg::dp_req_t  dp_req;
    dcache_pkg::dp_rsp_t  dp_rsp;
    dcache_pkg::mem_req_t mem;
    logic                 mem_wait;
    dcache_pkg::word_t    mem_load;

    dcache_pkg::word_t store [dcache_pkg::word_t];    // words written back to memory
    dcache_pkg::word_t written [dcache_pkg::word_t];  // words written by the datapath
    dcache_pkg::word_t rd_addrs [$];
    dcache_pkg::word_t wb_addrs [$];
    int                seed   = 32'h3e24_0707;
    int                checks = 0;
    int                errors = 0;

    // set 2 holds tags 1, 2 and 3 at 0x50, 0x90 and 0xd0
    // set 0 holds tags 8, 16 and 24 at 0x200, 0x400 and 0x600
    entry_t tests [N_ENTRIES] = '{
        '{OP_RD, 32'h050, 32'h0, 32'h050 ^ FILL_PAT, 1'b0, 0, 32'h0},  // cold miss fills way 0
        '{OP_RD, 32'h054, 32'h0, 32'h054 ^ FILL_PAT, 1'b1, 0, 32'h0},
        '{OP_WR, 32'h054, 32'hDEAD_BEEF, 32'h0, 1'b1, 0, 32'h0},
        '{OP_RD, 32'h054, 32'h0, 32'hDEAD_BEEF, 1'b1, 0, 32'h0},
        '{OP_RD, 32'h090, 32'h0, 32'h090 ^ FILL_PAT, 1'b0, 0, 32'h0},  // second tag goes to way 1
        '{OP_RD, 32'h050, 32'h0, 32'h050 ^ FILL_PAT, 1'b1, 0, 32'h0},  // makes tag 2 the LRU way
        '{OP_RD, 32'h0D0, 32'h0, 32'h0D0 ^ FILL_PAT, 1'b0, 0, 32'h0},
        '{OP_RD, 32'h050, 32'h0, 32'h050 ^ FILL_PAT, 1'b1, 0, 32'h0},
        '{OP_RD, 32'h090, 32'h0, 32'h090 ^ FILL_PAT, 1'b0, 0, 32'h0},  // tag 2 was evicted
        '{OP_RD, 32'h0D0, 32'h0, 32'h0D0 ^ FILL_PAT, 1'b0, 2, 32'h050},  // evicts dirty tag 1
        '{OP_RD, 32'h054, 32'h0, 32'hDEAD_BEEF, 1'b0, 0, 32'h0},
        '{OP_WR, 32'h204, 32'h1234_5678, 32'h0, 1'b0, 0, 32'h0},  // write miss
        '{OP_RD, 32'h400, 32'h0, 32'h400 ^ FILL_PAT, 1'b0, 0, 32'h0},
        '{OP_RD, 32'h600, 32'h0, 32'h600 ^ FILL_PAT, 1'b0, 2, 32'h200},
        '{OP_RD, 32'h204, 32'h0, 32'h1234_5678, 1'b0, 0, 32'h0}
    };

    dcache dut_i (.*);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    function automatic dcache_pkg::word_t mem_value(input dcache_pkg::word_t a);
        return store.exists(a) ? store[a] : a ^ FILL_PAT;
    endfunction

    function automatic dcache_pkg::word_t cached_value(input dcache_pkg::word_t a);
        return written.exists(a) ? written[a] : a ^ FILL_PAT;
    endfunction

    task automatic check_word(input string name, input dcache_pkg::word_t got,
                              input dcache_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_mem(input string name, input dcache_pkg::mem_req_t got,
                             input dcache_pkg::mem_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic run_entry(input int i);
        entry_t e;
        int     errs_before;
        logic   first_hit;
        e           = tests[i];
        errs_before = errors;
        rd_addrs.delete();
        wb_addrs.delete();
        @(posedge CLK);
        #2;
        dp_req.ren      = (e.op == OP_RD);
        dp_req.wen      = (e.op == OP_WR);
        dp_req.addr.raw = e.addr;
        dp_req.wdata    = e.wdata;
        @(negedge CLK);
        first_hit = dp_rsp.hit;
        while (dp_rsp.hit !== 1'b1) begin
            @(negedge CLK);
        end
        check_flag("hit", first_hit, e.hit_first);
        if (e.op == OP_RD) begin
            check_word("rdata", dp_rsp.rdata, e.rdata);
        end else begin
            written[e.addr] = e.wdata;
        end
        check_word("memory reads", rd_addrs.size(), e.hit_first ? 0 : 2);
        check_word("memory writes", wb_addrs.size(), e.n_wb);
        if (rd_addrs.size() == 2) begin
            check_word("fill addr", rd_addrs[0], {e.addr[31:3], 3'b000});  // word 0 then word 1
            check_word("fill addr", rd_addrs[1], {e.addr[31:3], 3'b100});
        end
        if (wb_addrs.size() == 2) begin
            check_word("write-back addr", wb_addrs[0], {e.wb_blk[31:3], 3'b000});
            check_word("write-back addr", wb_addrs[1], {e.wb_blk[31:3], 3'b100});
        end
        $display("entry %0d %s %h: %s", i, (e.op == OP_RD) ? "read" : "write", e.addr,
                 (errors == errs_before) ? "ok" : "failed");
    endtask

    // one transfer at a time, each held for 0 to 3 wait cycles
    initial begin : memory_model
        dcache_pkg::mem_req_t prev;
        logic                 live;
        logic                 fresh;
        int                   waits;
        prev     = '0;
        fresh    = 1'b1;
        waits    = 0;
        mem_wait = 1'b0;
        mem_load = '0;
        forever begin
            @(posedge CLK);
            live = prev.ren || prev.wen;
            if (live && !mem_wait) begin
                fresh = 1'b1;  // transfer taken at this edge
                if (prev.wen) begin
                    $display("  memory write %h <= %h", prev.addr, prev.wdata);
                    check_word("mem.wdata", prev.wdata, cached_value(prev.addr));
                    store[prev.addr] = prev.wdata;
                    wb_addrs.push_back(prev.addr);
                end else begin
                    rd_addrs.push_back(prev.addr);
                end
            end
            #1;
            if (live && mem_wait) begin
                check_mem("mem", mem, prev);  // request must hold through a wait cycle
            end
            if ((mem.ren || mem.wen) && fresh) begin
                waits = {$random(seed)} % 4;
                fresh = 1'b0;
            end
            prev = mem;
            #1;
            mem_wait = (prev.ren || prev.wen) && (waits > 0);
            waits    = (waits > 0) ? waits - 1 : 0;
            mem_load = prev.ren ? mem_value(prev.addr) : '0;
        end
    end

    initial begin : stimulus
        nRST   = 1'b0;
        dp_req = '0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #2;
        nRST = 1'b1;
        for (int i = 0; i < N_ENTRIES; i++) begin
            run_entry(i);
        end
        @(posedge CLK);
        #2;
        dp_req = '0;
        $display("%0d entries, %0d checks, %0d errors", N_ENTRIES, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // a dirty miss with the longest waits needs well under 40 cycles
    initial begin : watchdog
        repeat (RESET_CYCLES + N_ENTRIES * 40) @(posedge CLK);
        $display("timeout: the cache gave no hit within %0d cycles", N_ENTRIES * 40);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: dcache.sv
//##########################################################################
// data cache top level
// 2-way, 8-set write-back cache with 2-word blocks, joins the tag array,
// data array and miss controller
//##########################################################################
`timescale 1ns/1ns
`default_nettype none

module dcache (
    input  logic                 CLK,
    input  logic                 nRST,
    input  dcache_pkg::dp_req_t  dp_req,
    output dcache_pkg::dp_rsp_t  dp_rsp,
    output dcache_pkg::mem_req_t mem,
    input  logic                 mem_wait,
    input  dcache_pkg::word_t    mem_load
);

    logic                         hit;
    logic                         hit_way;
    logic                         victim_way;
    logic                         victim_dirty;
    logic [dcache_pkg::TAG_W-1:0] victim_tag;
    dcache_pkg::word_t            rdata;
    dcache_pkg::word_t            victim_word0;
    dcache_pkg::word_t            victim_word1;
    dcache_pkg::array_cmd_t       cmd;

    assign dp_rsp = '{hit: hit, rdata: rdata};  // hit doubles as the datapath ready

    dcache_tag_array tag_array_i (
        .CLK          (CLK),
        .nRST         (nRST),
        .req          (dp_req),
        .cmd          (cmd),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    dcache_data_array data_array_i (
        .CLK          (CLK),
        .nRST         (nRST),
        .req          (dp_req),
        .hit          (hit),
        .hit_way      (hit_way),
        .cmd          (cmd),
        .rdata        (rdata),
        .victim_word0 (victim_word0),
        .victim_word1 (victim_word1)
    );

    dcache_miss_ctrl miss_ctrl_i (
        .CLK          (CLK),
        .nRST         (nRST),
        .req          (dp_req),
        .hit          (hit),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_word0 (victim_word0),
        .victim_word1 (victim_word1),
        .mem_wait     (mem_wait),
        .mem_load     (mem_load),
        .mem          (mem),
        .cmd          (cmd)
    );

endmodule

`default_nettype wire

// File: dcache_miss_ctrl.sv
//##########################################################################
// data cache miss controller
// FSM for victim write-back and block fill, memory bus requests and the
// update commands for the tag and data arrays
//##########################################################################
`timescale 1ns/1ns
`default_nettype none

module dcache_miss_ctrl (
    input  logic                         CLK,
    input  logic                         nRST,
    input  dcache_pkg::dp_req_t          req,
    input  logic                         hit,
    input  logic                         victim_way,
    input  logic                         victim_dirty,
    input  logic [dcache_pkg::TAG_W-1:0] victim_tag,
    input  dcache_pkg::word_t            victim_word0,
    input  dcache_pkg::word_t            victim_word1,
    input  logic                         mem_wait,
    input  dcache_pkg::word_t            mem_load,
    output dcache_pkg::mem_req_t         mem,
    output dcache_pkg::array_cmd_t       cmd
);

    typedef enum logic [2:0] {IDLE, WB1, WB2, FILL1, FILL2} state_t;

    state_t             state;
    state_t             next_state;
    logic               way_q;     // victim way held for the whole miss
    logic               miss;
    logic               word_sel;
    dcache_pkg::daddr_u wb_addr;
    dcache_pkg::daddr_u fill_addr;

    assign miss     = (req.ren | req.wen) && !hit;
    assign word_sel = (state == WB2) || (state == FILL2);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            way_q <= 1'b0;
        end else begin
            state <= next_state;
            if (state == IDLE && miss) begin
                way_q <= victim_way;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (miss) begin
                    next_state = victim_dirty ? WB1 : FILL1;  // clean victims skip write-back
                end
            end
            WB1: begin
                if (!mem_wait) begin
                    next_state = WB2;
                end
            end
            WB2: begin
                if (!mem_wait) begin
                    next_state = FILL1;
                end
            end
            FILL1: begin
                if (!mem_wait) begin
                    next_state = FILL2;
                end
            end
            FILL2: begin
                if (!mem_wait) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_comb begin
        wb_addr.fields   = '{tag: victim_tag, idx: req.addr.fields.idx,
                             blk_off: word_sel, byte_off: 2'b00};
        fill_addr.fields = '{tag: req.addr.fields.tag, idx: req.addr.fields.idx,
                             blk_off: word_sel, byte_off: 2'b00};
    end

    // the way selects the victim words and tag, so it must not depend on them
    always_comb begin
        cmd.way       = (state == IDLE) ? victim_way : way_q;
        cmd.wb_done   = (state == WB2) && !mem_wait;
        cmd.fill_en   = ((state == FILL1) || (state == FILL2)) && !mem_wait;
        cmd.fill_word = word_sel;
        cmd.fill_data = mem_load;
    end

    // the request depends only on state and held inputs, so it stays put while mem_wait is high
    always_comb begin
        mem = '0;
        case (state)
            WB1, WB2: begin
                mem.wen   = 1'b1;
                mem.addr  = wb_addr.raw;
                mem.wdata = word_sel ? victim_word1 : victim_word0;
            end
            FILL1, FILL2: begin
                mem.ren  = 1'b1;
                mem.addr = fill_addr.raw;
            end
            default: begin
                mem = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: dcache_data_array.sv
//##########################################################################
// data cache word store
// two words per way per set, hit read mux, write hit and fill write port,
// victim words for write-back
//##########################################################################
`timescale 1ns/1ns
`default_nettype none

module dcache_data_array (
    input  logic                   CLK,
    input  logic                   nRST,
    input  dcache_pkg::dp_req_t    req,
    input  logic                   hit,
    input  logic                   hit_way,
    input  dcache_pkg::array_cmd_t cmd,
    output dcache_pkg::word_t      rdata,
    output dcache_pkg::word_t      victim_word0,
    output dcache_pkg::word_t      victim_word1
);

    dcache_pkg::word_t data [dcache_pkg::N_SETS][dcache_pkg::N_WAYS][2];

    logic [dcache_pkg::IDX_W-1:0] idx;
    logic                         blk_off;

    assign idx     = req.addr.fields.idx;
    assign blk_off = req.addr.fields.blk_off;

    assign rdata        = data[idx][hit_way][blk_off];
    assign victim_word0 = data[idx][cmd.way][0];  // way latched by the controller during a miss
    assign victim_word1 = data[idx][cmd.way][1];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < dcache_pkg::N_SETS; s++) begin
                for (int w = 0; w < dcache_pkg::N_WAYS; w++) begin
                    data[s][w][0] <= '0;
                    data[s][w][1] <= '0;
                end
            end
        end else begin
            if (hit && req.wen) begin
                data[idx][hit_way][blk_off] <= req.wdata;
            end
            if (cmd.fill_en) begin
                data[idx][cmd.way][cmd.fill_word] <= cmd.fill_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: dcache_tag_array.sv
//##########################################################################
// data cache tag store
// per-set tags, valid, dirty and LRU bits, tag compare for hit and hit way,
// victim selection for the miss controller
//##########################################################################
`timescale 1ns/1ns
`default_nettype none

module dcache_tag_array (
    input  logic                         CLK,
    input  logic                         nRST,
    input  dcache_pkg::dp_req_t          req,
    input  dcache_pkg::array_cmd_t       cmd,
    output logic                         hit,
    output logic                         hit_way,
    output logic                         victim_way,
    output logic                         victim_dirty,
    output logic [dcache_pkg::TAG_W-1:0] victim_tag
);

    logic [dcache_pkg::TAG_W-1:0]  tags  [dcache_pkg::N_SETS][dcache_pkg::N_WAYS];
    logic [dcache_pkg::N_WAYS-1:0] valid [dcache_pkg::N_SETS];
    logic [dcache_pkg::N_WAYS-1:0] dirty [dcache_pkg::N_SETS];
    logic [dcache_pkg::N_SETS-1:0] lru;  // way to replace next in each set

    logic [dcache_pkg::IDX_W-1:0]  idx;
    logic [dcache_pkg::TAG_W-1:0]  tag;
    logic [dcache_pkg::N_WAYS-1:0] match;
    logic                          access;

    assign idx    = req.addr.fields.idx;
    assign tag    = req.addr.fields.tag;
    assign access = req.ren | req.wen;  // an idle request never hits or misses

    always_comb begin
        for (int w = 0; w < dcache_pkg::N_WAYS; w++) begin
            match[w] = valid[idx][w] && (tags[idx][w] == tag);
        end
    end

    assign hit     = access && (|match);
    assign hit_way = match[1];

    assign victim_way   = lru[idx];
    assign victim_dirty = valid[idx][victim_way] && dirty[idx][victim_way];
    assign victim_tag   = tags[idx][cmd.way];  // follows the way held by the controller

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < dcache_pkg::N_SETS; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
            lru <= '0;  // way 0 goes first
        end else begin
            if (hit) begin
                lru[idx] <= ~hit_way;
                if (req.wen) begin
                    dirty[idx][hit_way] <= 1'b1;
                end
            end
            if (cmd.fill_en) begin
                // the block is invalid between its two fill words
                valid[idx][cmd.way] <= cmd.fill_word;
                if (cmd.fill_word) begin
                    dirty[idx][cmd.way] <= 1'b0;
                end
            end
            if (cmd.wb_done) begin
                dirty[idx][cmd.way] <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (cmd.fill_en && cmd.fill_word) begin
            tags[idx][cmd.way] <= tag;  // new tag goes in with the last word
        end
    end

endmodule

`default_nettype wire

// File: dcache_pkg.sv
//##########################################################################
// data cache shared definitions
// geometry constants, the address union that is decoded into lookup fields,
// and the datapath, memory bus and array update structs
//##########################################################################
`default_nettype none

package dcache_pkg;

    localparam int WORD_W = 32;
    localparam int N_SETS = 8;
    localparam int N_WAYS = 2;
    localparam int TAG_W  = 26;
    localparam int IDX_W  = 3;

    typedef logic [WORD_W-1:0] word_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] idx;
        logic             blk_off;  // selects the word within the block
        logic [1:0]       byte_off;
    } daddr_fields_t;

    // the same address goes out flat to memory and split up for lookup
    typedef union packed {
        word_t         raw;
        daddr_fields_t fields;
    } daddr_u;

    typedef struct packed {
        logic   ren;
        logic   wen;
        daddr_u addr;
        word_t  wdata;
    } dp_req_t;

    typedef struct packed {
        logic  hit;
        word_t rdata;
    } dp_rsp_t;

    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  fill_en;
        logic  fill_word;  // word of the block being loaded
        word_t fill_data;
        logic  wb_done;    // second write-back word accepted by memory
        logic  way;
    } array_cmd_t;

endpackage

`default_nettype wire
